// File: hdl/rv_isa_pkg.sv
// RV32IM execute encodings
package rv_isa_pkg;

    // Exact ALU operation
    typedef enum logic [4:0] {
        ALU_ADD    = 5'd0,
        ALU_SUB    = 5'd1,
        ALU_SLL    = 5'd2,
        ALU_SLT    = 5'd3,
        ALU_SLTU   = 5'd4,
        ALU_XOR    = 5'd5,
        ALU_SRL    = 5'd6,
        ALU_SRA    = 5'd7,
        ALU_OR     = 5'd8,
        ALU_AND    = 5'd9,
        ALU_MUL    = 5'd10,
        ALU_MULH   = 5'd11,
        ALU_MULHSU = 5'd12,
        ALU_MULHU  = 5'd13,
        ALU_DIV    = 5'd14,  // Iterative and holds the pipeline
        ALU_DIVU   = 5'd15,
        ALU_REM    = 5'd16,
        ALU_REMU   = 5'd17
    } alu_op_t;

    // Operand class that picks the ALU operand sources
    typedef enum logic [2:0] {
        OPC_LDST    = 3'b000,  // rs1 + imm
        OPC_BRANCH  = 3'b001,  // rs1 vs rs2
        OPC_REG_IMM = 3'b010,  // rs1 op (rs2 or imm)
        OPC_JAL     = 3'b011,  // Link value pc + 4
        OPC_LUI     = 3'b100,
        OPC_AUIPC   = 3'b101,
        OPC_JALR    = 3'b111
    } op_class_t;

    // Branch type in funct3 encoding
    typedef enum logic [2:0] {
        BR_BEQ  = 3'b000,
        BR_BNE  = 3'b001,
        BR_BLT  = 3'b100,
        BR_BGE  = 3'b101,
        BR_BLTU = 3'b110,
        BR_BGEU = 3'b111
    } branch_t;

    // The four codes served by the divider
    function automatic logic is_div_op(input alu_op_t op);
        return op inside {ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU};
    endfunction

endpackage

// File: hdl/rv_pipe_pkg.sv
// Pipeline stage bundles
package rv_pipe_pkg;

    // Decoded instruction entering execute
    typedef struct packed {
        logic                  valid;        // Single-cycle strobe
        logic [4:0]            rs1_addr;
        logic [4:0]            rs2_addr;
        logic [31:0]           rs1_value;    // Register file read data
        logic [31:0]           rs2_value;
        logic [31:0]           imm;
        logic [31:0]           pc;
        logic                  alu_src;      // 1 selects imm for R/I ops
        rv_isa_pkg::op_class_t op_class;
        rv_isa_pkg::alu_op_t   alu_op;
        rv_isa_pkg::branch_t   branch_type;
        logic                  is_branch;
        logic                  mem_write;
        logic                  mem_read;
        logic                  reg_write;
        logic                  mem_to_reg;
        logic [4:0]            reg_dest;
    } id_ex_t;

    // Forwarding source from a later stage
    typedef struct packed {
        logic        reg_write;
        logic [4:0]  reg_dest;
        logic [31:0] data;
    } fwd_src_t;

    // Execute result towards memory stage
    typedef struct packed {
        logic        valid;
        logic [31:0] result;
        logic [31:0] rs2_value;      // Store data
        logic        mem_write;
        logic        mem_read;
        logic        reg_write;
        logic        mem_to_reg;
        logic [4:0]  reg_dest;
        logic        branch_taken;   // Also set for JAL and JALR
        logic [31:0] branch_target;
    } ex_mem_t;

endpackage

// File: hdl/rv_forward_unit.sv
// Operand forwarding
module rv_forward_unit #(
    parameter int XLEN = 32
) (
    input  rv_pipe_pkg::id_ex_t   id_in,
    input  rv_pipe_pkg::fwd_src_t ex_mem_fwd,
    input  rv_pipe_pkg::fwd_src_t mem_wb_fwd,
    output rv_pipe_pkg::id_ex_t   id_fwd
);
    import rv_pipe_pkg::*;

    logic [XLEN-1:0] rs1_fwd;
    logic [XLEN-1:0] rs2_fwd;

    // Source writes the register being read and is not x0
    function automatic logic src_hit(input fwd_src_t src, input logic [4:0] addr);
        return src.reg_write && (src.reg_dest != 5'd0) && (src.reg_dest == addr);
    endfunction

    function automatic logic [XLEN-1:0] pick(
        input logic [4:0]      addr,
        input logic [XLEN-1:0] rf_value,
        input fwd_src_t        ex_src,
        input fwd_src_t        wb_src
    );
        if (src_hit(ex_src, addr))
            return ex_src.data;      // Youngest value wins
        else if (src_hit(wb_src, addr))
            return wb_src.data;
        else
            return rf_value;
    endfunction

    assign rs1_fwd = pick(id_in.rs1_addr, id_in.rs1_value, ex_mem_fwd, mem_wb_fwd);
    assign rs2_fwd = pick(id_in.rs2_addr, id_in.rs2_value, ex_mem_fwd, mem_wb_fwd);

    always_comb
    begin
        id_fwd           = id_in;
        id_fwd.rs1_value = rs1_fwd;
        id_fwd.rs2_value = rs2_fwd;
    end

endmodule

// File: hdl/rv_alu.sv
// ALU with multiplier and divider
module rv_alu #(
    parameter int XLEN = 32
) (
    input  logic                clk,
    input  logic                rst,
    input  rv_isa_pkg::alu_op_t alu_op,
    input  logic                start,
    input  logic [XLEN-1:0]     a,
    input  logic [XLEN-1:0]     b,
    output logic [XLEN-1:0]     result,
    output logic                zero,
    output logic                less_signed,
    output logic                less_unsigned,
    output logic                busy
);
    import rv_isa_pkg::*;

    localparam int SHW  = $clog2(XLEN);
    localparam int CNTW = $clog2(XLEN + 1);

    logic [XLEN-1:0]          diff;
    logic [SHW-1:0]           shamt;
    logic                     a_sgn;
    logic                     b_sgn;
    logic signed [2*XLEN+1:0] product;

    logic                     running;
    logic [CNTW-1:0]          count;
    logic                     div_signed;
    logic                     a_neg;
    logic                     b_neg;
    logic [XLEN-1:0]          quo_q;    // Dividend shifts out as the quotient shifts in
    logic [XLEN-1:0]          rem_q;
    logic [XLEN-1:0]          dvs_q;
    logic                     neg_quo;
    logic                     neg_rem;
    logic [XLEN:0]            rem_shift;
    logic [XLEN:0]            rem_trial;
    logic [XLEN-1:0]          quo_out;
    logic [XLEN-1:0]          rem_out;

    assign diff          = a - b;
    assign shamt         = b[SHW-1:0];
    assign zero          = (diff == '0);
    assign less_signed   = $signed(a) < $signed(b);
    assign less_unsigned = a < b;

    // One signed XLEN+1 multiplier covers all four variants
    assign a_sgn   = (alu_op == ALU_MULH) || (alu_op == ALU_MULHSU);
    assign b_sgn   = (alu_op == ALU_MULH);
    assign product = $signed({a_sgn & a[XLEN-1], a}) * $signed({b_sgn & b[XLEN-1], b});

    assign div_signed = (alu_op == ALU_DIV) || (alu_op == ALU_REM);
    assign a_neg      = div_signed & a[XLEN-1];
    assign b_neg      = div_signed & b[XLEN-1];

    assign rem_shift = {rem_q, quo_q[XLEN-1]};
    assign rem_trial = rem_shift - {1'b0, dvs_q};

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            running <= 1'b0;
            count   <= '0;
        end
        else if (start)
        begin
            running <= 1'b1;
            count   <= CNTW'(XLEN);
        end
        else if (running)
        begin
            count <= count - 1'b1;
            if (count == CNTW'(1))
                running <= 1'b0;    // Last quotient bit this edge
        end
    end

    // Restoring shift-subtract on magnitudes
    always_ff @(posedge clk)
    begin
        if (start)
        begin
            quo_q   <= a_neg ? -a : a;
            dvs_q   <= b_neg ? -b : b;
            rem_q   <= '0;
            neg_quo <= (a_neg ^ b_neg) && (b != '0);  // x/0 stays all ones
            neg_rem <= a_neg;                         // Remainder takes dividend sign
        end
        else if (running)
        begin
            if (!rem_trial[XLEN])
            begin
                rem_q <= rem_trial[XLEN-1:0];
                quo_q <= {quo_q[XLEN-2:0], 1'b1};
            end
            else
            begin
                rem_q <= rem_shift[XLEN-1:0];
                quo_q <= {quo_q[XLEN-2:0], 1'b0};
            end
        end
    end

    assign quo_out = neg_quo ? -quo_q : quo_q;
    assign rem_out = neg_rem ? -rem_q : rem_q;
    assign busy    = start | running;

    always_comb
    begin
        case (alu_op)
            ALU_ADD:    result = a + b;
            ALU_SUB:    result = diff;
            ALU_SLL:    result = a << shamt;
            ALU_SLT:    result = XLEN'(less_signed);
            ALU_SLTU:   result = XLEN'(less_unsigned);
            ALU_XOR:    result = a ^ b;
            ALU_SRL:    result = a >> shamt;
            ALU_SRA:    result = $signed(a) >>> shamt;
            ALU_OR:     result = a | b;
            ALU_AND:    result = a & b;
            ALU_MUL:    result = product[XLEN-1:0];
            ALU_MULH,
            ALU_MULHSU,
            ALU_MULHU:  result = product[2*XLEN-1:XLEN];
            ALU_DIV,
            ALU_DIVU:   result = quo_out;
            ALU_REM,
            ALU_REMU:   result = rem_out;
            default:    result = '0;
        endcase
    end

endmodule

// File: hdl/rv_branch_unit.sv
// Branch decision
module rv_branch_unit (
    input  logic                is_branch,
    input  rv_isa_pkg::branch_t branch_type,
    input  logic                zero,
    input  logic                less_signed,
    input  logic                less_unsigned,
    output logic                taken
);
    import rv_isa_pkg::*;

    logic cond;

    // Flags come from rs1 - rs2 comparison
    always_comb
    begin
        case (branch_type)
            BR_BEQ:  cond = zero;
            BR_BNE:  cond = !zero;
            BR_BLT:  cond = less_signed;
            BR_BGE:  cond = !less_signed;
            BR_BLTU: cond = less_unsigned;
            BR_BGEU: cond = !less_unsigned;
            default: cond = 1'b0;    // Reserved funct3
        endcase
    end

    assign taken = is_branch && cond;

endmodule

// File: hdl/rv_execute.sv
// Execute stage
module rv_execute #(
    parameter int XLEN = 32
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 stall,
    input  rv_pipe_pkg::id_ex_t  id_in,
    output rv_pipe_pkg::ex_mem_t ex_out,
    output logic                 busy
);
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    id_ex_t          id_q;
    logic            load;
    logic            div_start;
    logic            is_jump;
    alu_op_t         alu_op_eff;
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_result;
    logic            alu_zero;
    logic            alu_lt;
    logic            alu_ltu;
    logic            br_taken;
    logic [XLEN-1:0] target_sum;

    assign load = !stall && !busy;

    // ID/EX register
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            id_q <= '0;
        else if (load)
            id_q <= id_in;
    end

    // One-cycle divider kick on capture
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            div_start <= 1'b0;
        else
            div_start <= load && id_in.valid && (id_in.op_class == OPC_REG_IMM)
                         && is_div_op(id_in.alu_op);
    end

    assign is_jump = (id_q.op_class == OPC_JAL) || (id_q.op_class == OPC_JALR);

    // Only R/I ops use the decoded operation
    always_comb
    begin
        case (id_q.op_class)
            OPC_REG_IMM: alu_op_eff = id_q.alu_op;
            OPC_BRANCH:  alu_op_eff = ALU_SUB;
            default:     alu_op_eff = ALU_ADD;
        endcase
    end

    // Operand sources by class
    always_comb
    begin
        case (id_q.op_class)
            OPC_LDST,
            OPC_BRANCH,
            OPC_REG_IMM: op_a = id_q.rs1_value;
            OPC_LUI:     op_a = id_q.imm;
            OPC_AUIPC,
            OPC_JAL,
            OPC_JALR:    op_a = id_q.pc;
            default:     op_a = '0;
        endcase
        case (id_q.op_class)
            OPC_LDST,
            OPC_AUIPC:   op_b = id_q.imm;
            OPC_BRANCH:  op_b = id_q.rs2_value;
            OPC_REG_IMM: op_b = id_q.alu_src ? id_q.imm : id_q.rs2_value;
            OPC_JAL,
            OPC_JALR:    op_b = XLEN'(4);  // Link address
            default:     op_b = '0;
        endcase
    end

    rv_alu #(
        .XLEN (XLEN)
    ) i_alu (
        .clk           (clk),
        .rst           (rst),
        .alu_op        (alu_op_eff),
        .start         (div_start),
        .a             (op_a),
        .b             (op_b),
        .result        (alu_result),
        .zero          (alu_zero),
        .less_signed   (alu_lt),
        .less_unsigned (alu_ltu),
        .busy          (busy)
    );

    rv_branch_unit i_branch (
        .is_branch     (id_q.is_branch),
        .branch_type   (id_q.branch_type),
        .zero          (alu_zero),
        .less_signed   (alu_lt),
        .less_unsigned (alu_ltu),
        .taken         (br_taken)
    );

    // JALR target is rs1 based and halfword aligned
    assign target_sum = ((id_q.op_class == OPC_JALR) ? id_q.rs1_value : id_q.pc) + id_q.imm;

    always_comb
    begin
        ex_out.valid         = id_q.valid && !busy && !stall;  // One issue per capture
        ex_out.result        = alu_result;
        ex_out.rs2_value     = id_q.rs2_value;
        ex_out.mem_write     = id_q.mem_write;
        ex_out.mem_read      = id_q.mem_read;
        ex_out.reg_write     = id_q.reg_write;
        ex_out.mem_to_reg    = id_q.mem_to_reg;
        ex_out.reg_dest      = id_q.reg_dest;
        ex_out.branch_taken  = is_jump || br_taken;
        ex_out.branch_target = {target_sum[XLEN-1:1],
                                target_sum[0] && (id_q.op_class != OPC_JALR)};
    end

endmodule

// File: hdl/rv_ex_top.sv
// Execute stage top level
module rv_ex_top #(
    parameter int XLEN = 32
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  stall,
    input  rv_pipe_pkg::id_ex_t   id_in,
    input  rv_pipe_pkg::fwd_src_t ex_mem_fwd,
    input  rv_pipe_pkg::fwd_src_t mem_wb_fwd,
    output rv_pipe_pkg::ex_mem_t  ex_out,
    output logic                  busy
);
    import rv_pipe_pkg::*;

    id_ex_t id_fwd;    // Bundle with bypassed operands

    rv_forward_unit #(
        .XLEN (XLEN)
    ) i_forward (
        .id_in      (id_in),
        .ex_mem_fwd (ex_mem_fwd),
        .mem_wb_fwd (mem_wb_fwd),
        .id_fwd     (id_fwd)
    );

    rv_execute #(
        .XLEN (XLEN)
    ) i_execute (
        .clk    (clk),
        .rst    (rst),
        .stall  (stall),
        .id_in  (id_fwd),
        .ex_out (ex_out),
        .busy   (busy)
    );

endmodule

// File: tb/tb_clk_gen.sv
// Testbench clock and reset
module tb_clk_gen #(
    parameter int PERIOD       = 100,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic rst
);

    initial
    begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial
    begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #10 rst = 1'b0;    // Released with the other inputs
    end

endmodule

// File: tb/tb_rv_ex_top.sv
// Execute stage testbench
module tb_rv_ex_top;
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    localparam int XLEN        = 32;
    localparam int N_TESTS     = 75;    // Bundles issued over all tests
    localparam int CYCLE_LIMIT = N_TESTS * (XLEN + 10) + 100;

    logic        clk;
    logic        rst;
    logic        stall;
    id_ex_t      id_in;
    fwd_src_t    ex_mem_fwd;
    fwd_src_t    mem_wb_fwd;
    ex_mem_t     ex_out;
    logic        busy;
    logic [31:0] lfsr;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;

    tb_clk_gen #(
        .PERIOD       (100),
        .RESET_CYCLES (10)
    ) i_clk_gen (
        .clk (clk),
        .rst (rst)
    );

    rv_ex_top #(
        .XLEN (XLEN)
    ) i_dut (
        .clk        (clk),
        .rst        (rst),
        .stall      (stall),
        .id_in      (id_in),
        .ex_mem_fwd (ex_mem_fwd),
        .mem_wb_fwd (mem_wb_fwd),
        .ex_out     (ex_out),
        .busy       (busy)
    );

    // Galois form with taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};    // One step per bit
        end
        return v;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    function automatic id_ex_t make_bundle(input op_class_t cls, input alu_op_t op,
                                           input logic src);
        id_ex_t b;
        b           = '0;
        b.valid     = 1'b1;
        b.rs1_addr  = 5'(rand_bits(5));
        b.rs2_addr  = 5'(rand_bits(5));
        b.rs1_value = rand_bits(32);
        b.rs2_value = rand_bits(32);
        b.imm       = rand_bits(32);
        b.pc        = {30'(rand_bits(30)), 2'b00};
        b.alu_src   = src;
        b.op_class  = cls;
        b.alu_op    = op;
        b.reg_dest  = 5'(rand_bits(5));
        {b.mem_write, b.mem_read, b.reg_write, b.mem_to_reg} = 4'(rand_bits(4));
        return b;
    endfunction

    // Youngest matching source other than x0
    function automatic logic [31:0] fwd_value(input logic [4:0] addr, input logic [31:0] rf);
        if (addr != 5'd0 && ex_mem_fwd.reg_write && ex_mem_fwd.reg_dest == addr)
            return ex_mem_fwd.data;
        if (addr != 5'd0 && mem_wb_fwd.reg_write && mem_wb_fwd.reg_dest == addr)
            return mem_wb_fwd.data;
        return rf;
    endfunction

    function automatic logic [31:0] model_alu(input alu_op_t op, input logic [31:0] a,
                                              input logic [31:0] b);
        logic [63:0]        ss;
        logic [63:0]        su;
        logic [63:0]        uu;
        logic               ovf;
        logic signed [31:0] sq;
        logic signed [31:0] sr;
        ss  = {{32{a[31]}}, a} * {{32{b[31]}}, b};
        su  = {{32{a[31]}}, a} * {32'd0, b};
        uu  = {32'd0, a} * {32'd0, b};
        ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
        sq  = '0;
        sr  = '0;
        if (b != 32'd0 && !ovf)
        begin
            sq = $signed(a) / $signed(b);    // Truncates toward zero
            sr = $signed(a) % $signed(b);
        end
        case (op)
            ALU_ADD:    return a + b;
            ALU_SUB:    return a - b;
            ALU_SLL:    return a << b[4:0];
            ALU_SLT:    return {31'd0, $signed(a) < $signed(b)};
            ALU_SLTU:   return {31'd0, a < b};
            ALU_XOR:    return a ^ b;
            ALU_SRL:    return a >> b[4:0];
            ALU_SRA:    return $signed(a) >>> b[4:0];
            ALU_OR:     return a | b;
            ALU_AND:    return a & b;
            ALU_MUL:    return uu[31:0];
            ALU_MULH:   return ss[63:32];
            ALU_MULHSU: return su[63:32];
            ALU_MULHU:  return uu[63:32];
            ALU_DIV:    return (b == 32'd0) ? 32'hffff_ffff : (ovf ? a : sq);
            ALU_REM:    return (b == 32'd0) ? a : (ovf ? 32'd0 : sr);
            ALU_DIVU:   return (b == 32'd0) ? 32'hffff_ffff : a / b;
            ALU_REMU:   return (b == 32'd0) ? a : a % b;
            default:    return 32'd0;
        endcase
    endfunction

    function automatic logic model_branch(input branch_t t, input logic [31:0] a,
                                          input logic [31:0] b);
        case (t)
            BR_BEQ:  return a == b;
            BR_BNE:  return a != b;
            BR_BLT:  return $signed(a) < $signed(b);
            BR_BGE:  return $signed(a) >= $signed(b);
            BR_BLTU: return a < b;
            BR_BGEU: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    function automatic ex_mem_t model_out(input id_ex_t b);
        ex_mem_t     e;
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic        jump;
        rs1  = fwd_value(b.rs1_addr, b.rs1_value);
        rs2  = fwd_value(b.rs2_addr, b.rs2_value);
        jump = (b.op_class == OPC_JAL) || (b.op_class == OPC_JALR);
        e              = '0;
        e.valid        = 1'b1;
        e.rs2_value    = rs2;
        e.mem_write    = b.mem_write;
        e.mem_read     = b.mem_read;
        e.reg_write    = b.reg_write;
        e.mem_to_reg   = b.mem_to_reg;
        e.reg_dest     = b.reg_dest;
        e.branch_taken = jump || (b.is_branch && model_branch(b.branch_type, rs1, rs2));
        if (b.op_class == OPC_JALR)
            e.branch_target = (rs1 + b.imm) & ~32'd1;
        else
            e.branch_target = b.pc + b.imm;
        case (b.op_class)
            OPC_LDST:    e.result = rs1 + b.imm;
            OPC_BRANCH:  e.result = rs1 - rs2;    // Comparison difference
            OPC_REG_IMM: e.result = model_alu(b.alu_op, rs1, b.alu_src ? b.imm : rs2);
            OPC_LUI:     e.result = b.imm;
            OPC_AUIPC:   e.result = b.pc + b.imm;
            default:     e.result = b.pc + 32'd4;    // Link address
        endcase
        return e;
    endfunction

    task automatic compare_out(input ex_mem_t exp, input ex_mem_t got);
        check_value("ex_out.result", got.result, exp.result);
        check_value("ex_out.rs2_value", got.rs2_value, exp.rs2_value);
        check_value("ex_out control",
                    {got.mem_write, got.mem_read, got.reg_write, got.mem_to_reg, got.reg_dest},
                    {exp.mem_write, exp.mem_read, exp.reg_write, exp.mem_to_reg, exp.reg_dest});
        check_value("ex_out.branch_taken", got.branch_taken, exp.branch_taken);
        check_value("ex_out.branch_target", got.branch_target, exp.branch_target);
    endtask

    // Hold is offered right after capture and taken once busy is low
    task automatic issue_bundle(input id_ex_t b, input id_ex_t hold);
        ex_mem_t exp;
        ex_mem_t exp_hold;
        int      lat;
        int      busy_n;
        logic    div;
        exp      = model_out(b);
        exp_hold = model_out(hold);
        div      = (b.op_class == OPC_REG_IMM)
                   && (b.alu_op inside {ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU});
        lat      = 0;
        busy_n   = 0;
        id_in    = b;
        @(posedge clk);
        #10;
        id_in = hold;
        do
        begin
            @(negedge clk);
            lat++;
            busy_n += busy;
        end
        while (!ex_out.valid && lat <= XLEN + 10);
        if (!ex_out.valid)
        begin
            errors++;
            $display("No ex_out.valid within %0d cycles of issue", lat);
        end
        else
        begin
            compare_out(exp, ex_out);
            check_value("ex_out latency", lat, div ? XLEN + 2 : 1);
            check_value("busy cycles", busy_n, div ? XLEN + 1 : 0);
        end
        @(posedge clk);
        #10;
        id_in.valid = 1'b0;
        @(negedge clk);
        check_value("ex_out.valid", ex_out.valid, hold.valid);    // Single pulse per bundle
        if (hold.valid)
            compare_out(exp_hold, ex_out);
        @(posedge clk);
        #10;
    endtask

    task automatic reset_outputs_zero();
        @(negedge clk);
        check_value("ex_out.valid", ex_out.valid, 1'b0);
        check_value("busy", busy, 1'b0);
        check_value("ex_out control",
                    {ex_out.reg_write, ex_out.mem_write, ex_out.mem_read, ex_out.branch_taken},
                    4'h0);
    endtask

    task automatic alu_ops();
        alu_op_t op;
        for (int i = int'(ALU_ADD); i <= int'(ALU_MULHU); i++)
        begin
            op = alu_op_t'(i);
            issue_bundle(make_bundle(OPC_REG_IMM, op, 1'b0), '0);
            issue_bundle(make_bundle(OPC_REG_IMM, op, 1'b1), '0);
        end
    endtask

    task automatic operand_classes();
        id_ex_t b;
        issue_bundle(make_bundle(OPC_LDST, ALU_ADD, 1'b0), '0);
        issue_bundle(make_bundle(OPC_LUI, ALU_ADD, 1'b0), '0);
        issue_bundle(make_bundle(OPC_AUIPC, ALU_XOR, 1'b0), '0);    // Decoded op ignored
        issue_bundle(make_bundle(OPC_JAL, ALU_ADD, 1'b0), '0);
        b = make_bundle(OPC_JALR, ALU_ADD, 1'b1);
        b.imm[0] = ~b.rs1_value[0];    // Odd target before clearing bit 0
        issue_bundle(b, '0);
    endtask

    task automatic forwarding_paths();
        id_ex_t b;
        b          = make_bundle(OPC_REG_IMM, ALU_ADD, 1'b0);
        b.rs1_addr = 5'd7;
        b.rs2_addr = 5'd9;
        ex_mem_fwd = '{reg_write: 1'b1, reg_dest: 5'd7, data: rand_bits(32)};
        mem_wb_fwd = '{reg_write: 1'b1, reg_dest: 5'd7, data: rand_bits(32)};
        issue_bundle(b, '0);
        mem_wb_fwd.reg_dest = 5'd9;    // rs2 now from MEM/WB
        issue_bundle(b, '0);
        b.rs1_addr          = 5'd0;
        ex_mem_fwd.reg_dest = 5'd0;
        issue_bundle(b, '0);
        // Matching addresses but no write
        b.rs1_addr           = 5'd7;
        ex_mem_fwd.reg_dest  = 5'd7;
        ex_mem_fwd.reg_write = 1'b0;
        mem_wb_fwd.reg_write = 1'b0;
        issue_bundle(b, '0);
        ex_mem_fwd = '0;
        mem_wb_fwd = '0;
    endtask

    task automatic branch_outcomes();
        id_ex_t      b;
        logic [31:0] lo;
        logic [31:0] hi;
        for (int t = 0; t < 8; t++)    // Reserved encodings included
        begin
            for (int k = 0; k < 3; k++)
            begin
                b             = make_bundle(OPC_BRANCH, ALU_ADD, 1'b0);
                b.is_branch   = 1'b1;
                b.branch_type = branch_t'(t);
                lo            = {1'b0, 31'(rand_bits(31))};
                hi            = {1'b1, 31'(rand_bits(31))};
                b.rs1_value   = (k == 1) ? hi : lo;    // Equal, neg vs pos, pos vs neg
                b.rs2_value   = (k == 2) ? hi : lo;
                issue_bundle(b, '0);
            end
        end
    endtask

    task automatic divider_ops();
        id_ex_t b;
        for (int i = int'(ALU_DIV); i <= int'(ALU_REMU); i++)
        begin
            b           = make_bundle(OPC_REG_IMM, alu_op_t'(i), 1'b0);
            b.rs2_value = b.rs2_value >> 12;    // Nonzero quotients
            issue_bundle(b, '0);
            b.rs2_value = 32'd0;
            issue_bundle(b, '0);
            b.rs1_value = 32'h8000_0000;
            b.rs2_value = 32'hffff_ffff;
            issue_bundle(b, '0);
        end
    endtask

    task automatic offer_while_busy();
        id_ex_t d;
        id_ex_t x;
        d = make_bundle(OPC_REG_IMM, ALU_DIV, 1'b0);
        x = make_bundle(OPC_REG_IMM, ALU_XOR, 1'b1);
        issue_bundle(d, x);
    endtask

    task automatic stall_and_release();
        id_ex_t  b;
        ex_mem_t exp;
        b     = make_bundle(OPC_REG_IMM, ALU_SUB, 1'b0);
        exp   = model_out(b);
        id_in = b;
        @(posedge clk);
        #10;
        id_in.valid = 1'b0;
        stall       = 1'b1;
        repeat (3)
        begin
            @(negedge clk);
            check_value("ex_out.valid under stall", ex_out.valid, 1'b0);
        end
        @(posedge clk);
        #10;
        stall = 1'b0;
        @(negedge clk);
        check_value("ex_out.valid after stall", ex_out.valid, 1'b1);
        compare_out(exp, ex_out);
        @(posedge clk);
        #10;
        @(negedge clk);
        check_value("ex_out.valid after stall", ex_out.valid, 1'b0);
        @(posedge clk);
        #10;
    endtask

    always @(posedge clk)
    begin
        cycles++;
        if (cycles > CYCLE_LIMIT)
        begin
            $display("Timeout after %0d cycles, the tests did not finish", cycles);
            $display("%0d checks, %0d errors", checks, errors);
            $display("Checks failed");
            $finish;
        end
    end

    initial
    begin
        lfsr       = 32'hd7a9_5d3b;
        stall      = 1'b0;
        id_in      = '0;
        ex_mem_fwd = '0;
        mem_wb_fwd = '0;
        @(posedge clk);    // First edge applies the reset
        reset_outputs_zero();
        wait (!rst);
        reset_outputs_zero();
        @(posedge clk);
        #10;
        alu_ops();
        operand_classes();
        forwarding_paths();
        branch_outcomes();
        divider_ops();
        offer_while_busy();
        stall_and_release();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

// File: rv_ex.f
hdl/rv_isa_pkg.sv
hdl/rv_pipe_pkg.sv
hdl/rv_forward_unit.sv
hdl/rv_alu.sv
hdl/rv_branch_unit.sv
hdl/rv_execute.sv
hdl/rv_ex_top.sv
tb/tb_clk_gen.sv
tb/tb_rv_ex_top.sv

// File: Bender.yml
package:
  name: rv_ex

sources:
  - hdl/rv_isa_pkg.sv
  - hdl/rv_pipe_pkg.sv
  - hdl/rv_forward_unit.sv
  - hdl/rv_alu.sv
  - hdl/rv_branch_unit.sv
  - hdl/rv_execute.sv
  - hdl/rv_ex_top.sv
  - target: test
    files:
      - tb/tb_clk_gen.sv
      - tb/tb_rv_ex_top.sv
